//--- verilog/cpu_isa_pkg.sv
package cpu_isa_pkg;

        // ------------------------------------------------------------
        // widths
        // ------------------------------------------------------------
        localparam int word_width     = 16;
        localparam int reg_addr_width = 2;
        localparam int num_regs       = 4;

        typedef logic [word_width-1:0]     word_t;
        typedef logic [reg_addr_width-1:0] reg_addr_t;

        // ------------------------------------------------------------
        // encodings
        // ------------------------------------------------------------
        // opcode sits in instr[15:12]
        typedef enum logic [3:0] {
                op_adi   = 4'd4,
                op_ori   = 4'd5,
                op_lhi   = 4'd6,
                op_lwd   = 4'd7,
                op_swd   = 4'd8,
                op_rtype = 4'd15
        } opcode_e;

        // func field of r-type, instr[5:0]
        typedef enum logic [5:0] {
                fn_add = 6'd0,
                fn_sub = 6'd1,
                fn_and = 6'd2,
                fn_orr = 6'd3,
                fn_not = 6'd4,
                fn_tcp = 6'd5,
                fn_shl = 6'd6,
                fn_shr = 6'd7,
                fn_wwd = 6'd28,
                fn_hlt = 6'd29
        } func_e;

endpackage

//--- verilog/cpu_pipe_pkg.sv
package cpu_pipe_pkg;
        import cpu_isa_pkg::*;

        // first eight follow the r-type func numbering
        typedef enum logic [3:0] {
                alu_add = 4'd0,
                alu_sub = 4'd1,
                alu_and = 4'd2,
                alu_or  = 4'd3,
                alu_not = 4'd4,
                alu_tcp = 4'd5,
                alu_shl = 4'd6,
                alu_shr = 4'd7,
                alu_lhi = 4'd8
        } alu_op_e;

        typedef enum logic {
                wb_alu    = 1'b0,
                wb_memory = 1'b1
        } wb_src_e;

        typedef struct packed {
                alu_op_e alu_op;
                logic    alu_src_imm;  // operand b from imm
                logic    mem_read;
                logic    mem_write;
                logic    reg_write;
                wb_src_e wb_src;
                logic    is_output;    // wwd
        } ctrl_t;

        typedef struct packed {
                logic      valid;
                ctrl_t     ctrl;
                word_t     rs_data;
                word_t     rt_data;
                word_t     imm;
                reg_addr_t dest;
                logic      is_halt;
        } id_ex_t;

        typedef struct packed {
                logic      valid;
                ctrl_t     ctrl;
                word_t     alu_out;
                word_t     store_data;
                reg_addr_t dest;
                logic      is_halt;
        } ex_mem_t;

endpackage

//--- verilog/hazard_if.sv
interface hazard_if;
        import cpu_isa_pkg::*;

        // one write-enable/destination pair per stage past decode
        logic      ex_we;
        reg_addr_t ex_dest;
        logic      mem_we;
        reg_addr_t mem_dest;
        logic      wb_we;
        reg_addr_t wb_dest;

        modport ex_src (
                output ex_we, ex_dest
        );

        modport mem_src (
                output mem_we, mem_dest,
                output wb_we, wb_dest
        );

        modport check (
                input ex_we, ex_dest,
                input mem_we, mem_dest,
                input wb_we, wb_dest
        );

endinterface

//--- verilog/fetch_unit.sv
module fetch_unit (
        input  logic               clk,
        input  logic               reset_n,
        input  logic               i_stall,
        input  logic               i_halt_seen,
        input  cpu_isa_pkg::word_t i_i_data,
        output cpu_isa_pkg::word_t o_i_address,
        output logic               o_i_read,
        output logic               o_if_valid,
        output cpu_isa_pkg::word_t o_if_instr
);
        import cpu_isa_pkg::*;

        word_t pc;
        logic  running;         // set one cycle after reset leaves

        assign o_i_address = pc;
        assign o_i_read    = running && !i_halt_seen;

        // pc holds on stall or once hlt reached decode
        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        pc      <= '0;
                        running <= 1'b0;
                end else begin
                        running <= 1'b1;
                        if (running && !i_stall && !i_halt_seen)
                                pc <= pc + 1'b1;
                end
        end

        // ------------------------------------------------------------
        // IF/ID register
        // ------------------------------------------------------------
        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        o_if_valid <= 1'b0;
                end else if (!i_stall) begin
                        o_if_valid <= running && !i_halt_seen;
                        o_if_instr <= i_i_data;
                end
        end

endmodule

//--- verilog/decode_unit.sv
module decode_unit (
        input  logic                    clk,
        input  logic                    reset_n,
        input  logic                    i_if_valid,
        input  cpu_isa_pkg::word_t      i_if_instr,
        output cpu_isa_pkg::reg_addr_t  o_rs_addr,
        output cpu_isa_pkg::reg_addr_t  o_rt_addr,
        input  cpu_isa_pkg::word_t      i_rs_data,
        input  cpu_isa_pkg::word_t      i_rt_data,
        hazard_if.check                 hz,
        output logic                    o_stall,
        output logic                    o_halt_seen,
        output cpu_pipe_pkg::id_ex_t    o_id_ex
);
        import cpu_isa_pkg::*;
        import cpu_pipe_pkg::*;

        opcode_e   opcode;
        func_e     func;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        word_t     imm;
        ctrl_t     ctrl;
        logic      uses_rs;
        logic      uses_rt;
        logic      is_hlt;
        logic      hlt_now;
        logic      halt_q;     // sticky, hlt already passed decode

        // true if some in-flight writer still owns this register
        function automatic logic pending(input reg_addr_t addr);
                return (hz.ex_we && hz.ex_dest == addr) ||
                       (hz.mem_we && hz.mem_dest == addr) ||
                       (hz.wb_we && hz.wb_dest == addr);
        endfunction

        assign opcode    = opcode_e'(i_if_instr[15:12]);
        assign func      = func_e'(i_if_instr[5:0]);
        assign rs        = i_if_instr[11:10];
        assign rt        = i_if_instr[9:8];
        assign rd        = i_if_instr[7:6];
        assign o_rs_addr = rs;
        assign o_rt_addr = rt;

        // r-type gets zero so wwd can pass rs through the adder
        assign imm = (opcode == op_rtype) ? '0 :
                     {{(word_width-8){i_if_instr[7]}}, i_if_instr[7:0]};

        // ------------------------------------------------------------
        // control decode
        // ------------------------------------------------------------
        always_comb begin
                ctrl    = '0;
                uses_rs = 1'b0;
                uses_rt = 1'b0;
                is_hlt  = 1'b0;
                case (opcode)
                        op_adi, op_ori, op_lhi: begin
                                ctrl.alu_op      = (opcode == op_ori) ? alu_or :
                                                   (opcode == op_lhi) ? alu_lhi : alu_add;
                                ctrl.alu_src_imm = 1'b1;
                                ctrl.reg_write   = 1'b1;
                                uses_rs          = (opcode != op_lhi);
                        end
                        op_lwd: begin
                                ctrl.alu_src_imm = 1'b1;     // rs + imm
                                ctrl.mem_read    = 1'b1;
                                ctrl.reg_write   = 1'b1;
                                ctrl.wb_src      = wb_memory;
                                uses_rs          = 1'b1;
                        end
                        op_swd: begin
                                ctrl.alu_src_imm = 1'b1;
                                ctrl.mem_write   = 1'b1;
                                uses_rs          = 1'b1;
                                uses_rt          = 1'b1;     // store data
                        end
                        op_rtype: begin
                                uses_rs = (func != fn_hlt);
                                case (func)
                                        fn_add, fn_sub, fn_and, fn_orr,
                                        fn_not, fn_tcp, fn_shl, fn_shr: begin
                                                ctrl.alu_op    = alu_op_e'({1'b0, func[2:0]});
                                                ctrl.reg_write = 1'b1;
                                                uses_rt        = (func <= fn_orr);
                                        end
                                        fn_wwd: begin
                                                ctrl.alu_src_imm = 1'b1;
                                                ctrl.is_output   = 1'b1;
                                        end
                                        fn_hlt:  is_hlt = 1'b1;
                                        default: ;
                                endcase
                        end
                        default: ;      // unknown opcode retires as nop
                endcase
        end

        assign hlt_now     = i_if_valid && is_hlt && !halt_q;
        assign o_halt_seen = halt_q || hlt_now;
        assign o_stall     = i_if_valid && !halt_q &&
                             ((uses_rs && pending(rs)) || (uses_rt && pending(rt)));

        // ------------------------------------------------------------
        // ID/EX register, bubble on stall or after hlt
        // ------------------------------------------------------------
        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        halt_q        <= 1'b0;
                        o_id_ex.valid <= 1'b0;
                end else begin
                        if (hlt_now)
                                halt_q <= 1'b1;
                        o_id_ex.valid   <= i_if_valid && !o_stall && !halt_q;
                        o_id_ex.ctrl    <= ctrl;
                        o_id_ex.rs_data <= i_rs_data;
                        o_id_ex.rt_data <= i_rt_data;
                        o_id_ex.imm     <= imm;
                        o_id_ex.dest    <= (opcode == op_rtype) ? rd : rt;
                        o_id_ex.is_halt <= is_hlt;
                end
        end

endmodule

//--- verilog/register_file.sv
module register_file (
        input  logic                   clk,
        input  logic                   reset_n,
        input  cpu_isa_pkg::reg_addr_t i_rs_addr,
        input  cpu_isa_pkg::reg_addr_t i_rt_addr,
        output cpu_isa_pkg::word_t     o_rs_data,
        output cpu_isa_pkg::word_t     o_rt_data,
        input  logic                   i_write,
        input  cpu_isa_pkg::reg_addr_t i_write_addr,
        input  cpu_isa_pkg::word_t     i_write_data
);
        import cpu_isa_pkg::*;

        word_t regs [num_regs];

        // reads are combinational, no write-through
        assign o_rs_data = regs[i_rs_addr];
        assign o_rt_data = regs[i_rt_addr];

        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        for (int i = 0; i < num_regs; i++)
                                regs[i] <= '0;
                end else if (i_write) begin
                        regs[i_write_addr] <= i_write_data;
                end
        end

endmodule

//--- verilog/execute_unit.sv
module execute_unit (
        input  logic                  clk,
        input  logic                  reset_n,
        input  cpu_pipe_pkg::id_ex_t  i_id_ex,
        hazard_if.ex_src              hz,
        output cpu_pipe_pkg::ex_mem_t o_ex_mem
);
        import cpu_isa_pkg::*;
        import cpu_pipe_pkg::*;

        word_t op_a;
        word_t op_b;
        word_t alu_out;

        assign op_a = i_id_ex.rs_data;
        assign op_b = i_id_ex.ctrl.alu_src_imm ? i_id_ex.imm : i_id_ex.rt_data;

        // destination of the instruction now in EX
        assign hz.ex_we   = i_id_ex.valid && i_id_ex.ctrl.reg_write;
        assign hz.ex_dest = i_id_ex.dest;

        // ------------------------------------------------------------
        // ALU, 16 bit wraparound
        // ------------------------------------------------------------
        always_comb begin
                case (i_id_ex.ctrl.alu_op)
                        alu_add: alu_out = op_a + op_b;
                        alu_sub: alu_out = op_a - op_b;
                        alu_and: alu_out = op_a & op_b;
                        alu_or:  alu_out = op_a | op_b;
                        alu_not: alu_out = ~op_a;
                        alu_tcp: alu_out = ~op_a + 1'b1;
                        alu_shl: alu_out = {op_a[word_width-2:0], 1'b0};
                        alu_shr: alu_out = {op_a[word_width-1], op_a[word_width-1:1]}; // arith
                        alu_lhi: alu_out = {op_b[7:0], 8'h00};
                        default: alu_out = '0;
                endcase
        end

        // EX/MEM register
        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        o_ex_mem.valid <= 1'b0;
                end else begin
                        o_ex_mem.valid      <= i_id_ex.valid;
                        o_ex_mem.ctrl       <= i_id_ex.ctrl;
                        o_ex_mem.alu_out    <= alu_out;
                        o_ex_mem.store_data <= i_id_ex.rt_data;
                        o_ex_mem.dest       <= i_id_ex.dest;
                        o_ex_mem.is_halt    <= i_id_ex.is_halt;
                end
        end

endmodule

//--- verilog/memory_writeback.sv
module memory_writeback (
        input  logic                   clk,
        input  logic                   reset_n,
        input  cpu_pipe_pkg::ex_mem_t  i_ex_mem,
        output cpu_isa_pkg::word_t     o_d_address,
        output logic                   o_d_read,
        output logic                   o_d_write,
        output cpu_isa_pkg::word_t     o_d_wdata,
        input  cpu_isa_pkg::word_t     i_d_data,
        hazard_if.mem_src              hz,
        output logic                   o_rf_write,
        output cpu_isa_pkg::reg_addr_t o_rf_write_addr,
        output cpu_isa_pkg::word_t     o_rf_write_data,
        output cpu_isa_pkg::word_t     o_output_port,
        output logic                   o_output_active,
        output logic                   o_is_halted,
        output cpu_isa_pkg::word_t     o_num_inst
);
        import cpu_isa_pkg::*;
        import cpu_pipe_pkg::*;

        ex_mem_t mem_wb;
        word_t   wb_load;       // word read during MEM

        // ------------------------------------------------------------
        // MEM
        // ------------------------------------------------------------
        assign o_d_address = i_ex_mem.alu_out;
        assign o_d_read    = i_ex_mem.valid && i_ex_mem.ctrl.mem_read;
        assign o_d_write   = i_ex_mem.valid && i_ex_mem.ctrl.mem_write;
        assign o_d_wdata   = i_ex_mem.store_data;

        assign hz.mem_we   = i_ex_mem.valid && i_ex_mem.ctrl.reg_write;
        assign hz.mem_dest = i_ex_mem.dest;

        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        mem_wb.valid <= 1'b0;
                end else begin
                        mem_wb  <= i_ex_mem;
                        wb_load <= i_d_data;
                end
        end

        // ------------------------------------------------------------
        // WB
        // ------------------------------------------------------------
        assign o_rf_write      = mem_wb.valid && mem_wb.ctrl.reg_write;
        assign o_rf_write_addr = mem_wb.dest;
        assign o_rf_write_data = (mem_wb.ctrl.wb_src == wb_memory) ? wb_load : mem_wb.alu_out;

        assign hz.wb_we   = o_rf_write;
        assign hz.wb_dest = mem_wb.dest;

        assign o_output_port   = mem_wb.alu_out;        // rs + 0 for wwd
        assign o_output_active = mem_wb.valid && mem_wb.ctrl.is_output;

        // retirement count and halt flag
        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        o_num_inst  <= '0;
                        o_is_halted <= 1'b0;
                end else if (mem_wb.valid) begin
                        o_num_inst <= o_num_inst + 1'b1;
                        if (mem_wb.is_halt)
                                o_is_halted <= 1'b1;
                end
        end

endmodule

//--- verilog/cpu_top.sv
module cpu_top (
        input  logic               clk,
        input  logic               reset_n,
        output cpu_isa_pkg::word_t o_i_address,
        output logic               o_i_read,
        input  cpu_isa_pkg::word_t i_i_data,
        output cpu_isa_pkg::word_t o_d_address,
        output logic               o_d_read,
        output logic               o_d_write,
        output cpu_isa_pkg::word_t o_d_wdata,
        input  cpu_isa_pkg::word_t i_d_data,
        output cpu_isa_pkg::word_t o_output_port,
        output logic               o_output_active,
        output logic               o_is_halted,
        output cpu_isa_pkg::word_t o_num_inst
);
        import cpu_isa_pkg::*;
        import cpu_pipe_pkg::*;

        logic      stall;
        logic      halt_seen;
        logic      if_valid;
        word_t     if_instr;
        reg_addr_t rs_addr;
        reg_addr_t rt_addr;
        word_t     rs_data;
        word_t     rt_data;
        id_ex_t    id_ex;
        ex_mem_t   ex_mem;
        logic      rf_write;
        reg_addr_t rf_write_addr;
        word_t     rf_write_data;

        hazard_if u_hz ();

        fetch_unit u_fetch (
                .clk         (clk),
                .reset_n     (reset_n),
                .i_stall     (stall),
                .i_halt_seen (halt_seen),
                .i_i_data    (i_i_data),
                .o_i_address (o_i_address),
                .o_i_read    (o_i_read),
                .o_if_valid  (if_valid),
                .o_if_instr  (if_instr)
        );

        decode_unit u_decode (
                .clk         (clk),
                .reset_n     (reset_n),
                .i_if_valid  (if_valid),
                .i_if_instr  (if_instr),
                .o_rs_addr   (rs_addr),
                .o_rt_addr   (rt_addr),
                .i_rs_data   (rs_data),
                .i_rt_data   (rt_data),
                .hz          (u_hz.check),
                .o_stall     (stall),
                .o_halt_seen (halt_seen),
                .o_id_ex     (id_ex)
        );

        register_file u_rf (
                .clk          (clk),
                .reset_n      (reset_n),
                .i_rs_addr    (rs_addr),
                .i_rt_addr    (rt_addr),
                .o_rs_data    (rs_data),
                .o_rt_data    (rt_data),
                .i_write      (rf_write),
                .i_write_addr (rf_write_addr),
                .i_write_data (rf_write_data)
        );

        execute_unit u_execute (
                .clk      (clk),
                .reset_n  (reset_n),
                .i_id_ex  (id_ex),
                .hz       (u_hz.ex_src),
                .o_ex_mem (ex_mem)
        );

        memory_writeback u_mem_wb (
                .clk             (clk),
                .reset_n         (reset_n),
                .i_ex_mem        (ex_mem),
                .o_d_address     (o_d_address),
                .o_d_read        (o_d_read),
                .o_d_write       (o_d_write),
                .o_d_wdata       (o_d_wdata),
                .i_d_data        (i_d_data),
                .hz              (u_hz.mem_src),
                .o_rf_write      (rf_write),
                .o_rf_write_addr (rf_write_addr),
                .o_rf_write_data (rf_write_data),
                .o_output_port   (o_output_port),
                .o_output_active (o_output_active),
                .o_is_halted     (o_is_halted),
                .o_num_inst      (o_num_inst)
        );

endmodule

//--- tb/cpu_tb.sv
module cpu_tb;
        import cpu_isa_pkg::*;

        localparam int clk_period   = 4;
        localparam int reset_cycles = 8;
        localparam int drain_cycles = 10;       // cycles watched after halt

        logic  clk;
        logic  reset_n;
        word_t o_i_address;
        logic  o_i_read;
        word_t i_i_data;
        word_t o_d_address;
        logic  o_d_read;
        logic  o_d_write;
        word_t o_d_wdata;
        word_t i_d_data;
        word_t o_output_port;
        logic  o_output_active;
        logic  o_is_halted;
        word_t o_num_inst;

        word_t imem [0:65535];
        word_t dmem [0:65535];
        word_t exp_out [$];     // wwd values in program order
        word_t mem_addr [$];
        word_t mem_data [$];
        word_t exp_num = '0;
        int    prog_len = 0;
        int    limit_cycles = 0;
        int    out_idx = 0;
        int    checks = 0;
        int    errors = 0;
        bit    loaded = 1'b0;
        bit    halt_latched = 1'b0;

        cpu_top i_cpu_top (
                .clk             (clk),
                .reset_n         (reset_n),
                .o_i_address     (o_i_address),
                .o_i_read        (o_i_read),
                .i_i_data        (i_i_data),
                .o_d_address     (o_d_address),
                .o_d_read        (o_d_read),
                .o_d_write       (o_d_write),
                .o_d_wdata       (o_d_wdata),
                .i_d_data        (i_d_data),
                .o_output_port   (o_output_port),
                .o_output_active (o_output_active),
                .o_is_halted     (o_is_halted),
                .o_num_inst      (o_num_inst)
        );

        initial clk = 1'b0;
        always #(clk_period / 2) clk = ~clk;

        // ------------------------------------------------------------
        // ideal memory models
        // ------------------------------------------------------------
        assign i_i_data = imem[o_i_address];
        assign i_d_data = o_d_read ? dmem[o_d_address] : 'x;    // data only on a read

        always @(posedge clk) begin
                if (o_d_write)
                        dmem[o_d_address] <= o_d_wdata;
        end

        task automatic check_value(input string what, input word_t got, input word_t exp);
                checks++;
                assert (got === exp) else begin
                        errors++;
                        $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
                end
        endtask

        task automatic report_counts();
                $display("checks: %0d, errors: %0d", checks, errors);
        endtask

        // reads tagged lines where a # token skips to end of line
        task automatic read_test_file(output bit ok);
                integer        fd;
                integer        n;
                logic [63:0]   tag;
                logic [2047:0] rest;
                word_t         addr;
                word_t         data;
                int            i;
                for (i = 0; i < 65536; i++) begin
                        imem[i] = '0;                           // opcode 0 decodes as nop
                        dmem[i] = word_t'(i) ^ 16'h5ac3;
                end
                ok = 1'b0;
                fd = $fopen("tb/cpu_stim.txt", "r");
                if (fd != 0) begin
                        while ($fscanf(fd, "%s", tag) == 1) begin
                                case (tag)
                                        "#": n = $fgets(rest, fd);
                                        "I": begin
                                                n = $fscanf(fd, "%h %h", addr, data);
                                                imem[addr] = data;
                                                prog_len++;
                                        end
                                        "D": begin
                                                n = $fscanf(fd, "%h %h", addr, data);
                                                dmem[addr] = data;
                                        end
                                        "O": begin
                                                n = $fscanf(fd, "%h", data);
                                                exp_out.push_back(data);
                                        end
                                        "N": n = $fscanf(fd, "%h", exp_num);
                                        "M": begin
                                                n = $fscanf(fd, "%h %h", addr, data);
                                                mem_addr.push_back(addr);
                                                mem_data.push_back(data);
                                        end
                                        default: begin
                                                errors++;
                                                $display("unknown tag in test file, line skipped");
                                                n = $fgets(rest, fd);
                                        end
                                endcase
                        end
                        $fclose(fd);
                        ok = 1'b1;
                end
        endtask

        // ------------------------------------------------------------
        // output port and halt flag sampled mid-cycle
        // ------------------------------------------------------------
        always @(negedge clk) begin
                if (reset_n) begin
                        if (o_output_active) begin
                                assert (!o_is_halted) else begin
                                        errors++;
                                        $display("output pulse at time %0t after the halt flag rose",
                                                 $time);
                                end
                                assert (out_idx < exp_out.size()) else begin
                                        errors++;
                                        $display("more WWD outputs than expected at time %0t", $time);
                                end
                                if (out_idx < exp_out.size())
                                        check_value("o_output_port", o_output_port, exp_out[out_idx]);
                                out_idx++;
                        end
                        if (halt_latched) begin
                                assert (o_is_halted) else begin
                                        errors++;
                                        $display("halt flag dropped at time %0t", $time);
                                end
                        end
                        halt_latched = halt_latched || o_is_halted;
                end
        end

        // watchdog allows about five cycles per instruction
        initial begin
                wait (loaded);
                repeat (limit_cycles) @(posedge clk);
                $display("timeout: processor never halted within %0d cycles", limit_cycles);
                report_counts();
                $display("TESTS FAILED");
                $finish;
        end

        initial begin : main_flow
                bit ok;
                reset_n = 1'b0;
                read_test_file(ok);
                if (!ok) begin
                        $display("cannot open tb/cpu_stim.txt");
                        $display("TESTS FAILED");
                        $finish;
                end else begin
                        limit_cycles = reset_cycles + 5 * prog_len + 20;
                        loaded       = 1'b1;
                        repeat (reset_cycles) @(negedge clk);
                        check_value("o_d_read in reset", o_d_read, 1'b0);
                        check_value("o_d_write in reset", o_d_write, 1'b0);
                        check_value("o_output_active in reset", o_output_active, 1'b0);
                        check_value("o_is_halted in reset", o_is_halted, 1'b0);
                        check_value("o_num_inst in reset", o_num_inst, '0);
                        reset_n = 1'b1;

                        @(negedge clk);
                        check_value("o_i_read after reset", o_i_read, 1'b1);
                        check_value("o_i_address after reset", o_i_address, '0);

                        while (!o_is_halted)
                                @(negedge clk);
                        check_value("o_num_inst at halt", o_num_inst, exp_num);
                        check_value("o_i_read at halt", o_i_read, 1'b0);
                        repeat (drain_cycles) @(negedge clk);     // nothing may retire now

                        assert (out_idx == exp_out.size()) else begin
                                errors++;
                                $display("only %0d of %0d expected outputs appeared",
                                         out_idx, exp_out.size());
                        end
                        foreach (mem_addr[k])
                                check_value($sformatf("dmem[%h]", mem_addr[k]),
                                            dmem[mem_addr[k]], mem_data[k]);

                        report_counts();
                        if (errors == 0)
                                $display("TESTS PASSED");
                        else
                                $display("TESTS FAILED");
                        $finish;
                end
        end

endmodule

//--- tb/cpu_stim.txt
# columns: tag then hex fields; I addr instr, D addr initial data, M addr final data
# O expected wwd value in order, N retired count at halt
I 0000 6112 # lhi  r1, 12
I 0001 5534 # ori  r1, r1, 34      back-to-back on r1
I 0002 42fd # adi  r2, r0, -3
I 0003 f6c0 # add  r3, r1, r2
I 0004 fc1c # wwd  r3
I 0005 f6c1 # sub  r3, r1, r2
I 0006 fc1c # wwd  r3
I 0007 fe02 # and  r0, r3, r2
I 0008 f01c # wwd  r0
I 0009 5680 # ori  r2, r1, sext 80
I 000a f8c3 # orr  r3, r2, r0
I 000b fcc4 # not  r3, r3
I 000c fc45 # tcp  r1, r3
I 000d f447 # shr  r1, r1
I 000e f41c # wwd  r1
I 000f f006 # shl  r0, r0
I 0010 8c10 # swd  r0, 10(r3)
I 0011 7e10 # lwd  r2, 10(r3)
I 0012 f81c # wwd  r2
I 0013 7765 # lwd  r3, 65(r1)      wraps to 0040
I 0014 83fe # swd  r3, -2(r0)
I 0015 fc1c # wwd  r3
I 0016 4e01 # adi  r2, r3, 1
I 0017 f81c # wwd  r2              right behind its producer
I 0018 4c01 # adi  r0, r3, 1
I 0019 617f # lhi  r1, 7f
I 001a f41c # wwd  r1
I 001b f01c # wwd  r0              same value, three apart
I 001c f01d # hlt
I 001d f41c # wwd  r1              past hlt
I 001e 4501 # adi  r1, r1, 1
D 0040 beef
O 1231
O 1237
O 1235
O ffdb
O 246a
O beef
O bef0
O 7f00
O bef0
N 001d
M 005a 246a
M 0040 beef
M 2468 beef

//--- files.f
verilog/cpu_isa_pkg.sv
verilog/cpu_pipe_pkg.sv
verilog/hazard_if.sv
verilog/fetch_unit.sv
verilog/decode_unit.sv
verilog/register_file.sv
verilog/execute_unit.sv
verilog/memory_writeback.sv
verilog/cpu_top.sv
tb/cpu_tb.sv
